/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCpu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import cpuIsaPkg::*, cpuBusPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  aluPortIf.unit  alu
);

  dataT       regA;
  logic [3:0] flags;
  dataT       result;
  dataT       operandB;
  logic       carryIn;
  logic [8:0] addWide;
  logic [8:0] subWide;
  logic [4:0] addHalf;
  logic [4:0] subHalf;
  dataT       nextResult;
  logic [3:0] nextFlags;

  assign operandB = ((alu.op == aluInc) || (alu.op == aluDec)) ? dataT'(1) : alu.y;
  assign carryIn  = ((alu.op == aluAdc) || (alu.op == aluSbc)) ? flags[flagCarry] : 1'b0;

  assign addWide = {1'b0, alu.x} + {1'b0, operandB} + 9'(carryIn);
  assign subWide = {1'b0, alu.x} - {1'b0, operandB} - 9'(carryIn);
  assign addHalf = {1'b0, alu.x[3:0]} + {1'b0, operandB[3:0]} + 5'(carryIn);
  assign subHalf = {1'b0, alu.x[3:0]} - {1'b0, operandB[3:0]} - 5'(carryIn);   // Bit 4 is borrow

  always_comb
  begin
    nextResult = alu.x;
    nextFlags  = flags;
    case (alu.op)
      aluAdd, aluAdc, aluInc:
      begin
        nextResult          = addWide[7:0];
        nextFlags[flagSub]  = 1'b0;
        nextFlags[flagHalf] = addHalf[4];
        if (alu.op != aluInc)
          nextFlags[flagCarry] = addWide[8];
      end
      aluSub, aluSbc, aluCp, aluDec:
      begin
        nextResult          = subWide[7:0];
        nextFlags[flagSub]  = 1'b1;
        nextFlags[flagHalf] = subHalf[4];
        if (alu.op != aluDec)
          nextFlags[flagCarry] = subWide[8];
      end
      aluAnd:
      begin
        nextResult           = alu.x & alu.y;
        nextFlags[flagSub]   = 1'b0;
        nextFlags[flagHalf]  = 1'b1;
        nextFlags[flagCarry] = 1'b0;
      end
      aluXor, aluOr:
      begin
        nextResult           = (alu.op == aluXor) ? (alu.x ^ alu.y) : (alu.x | alu.y);
        nextFlags[flagSub]   = 1'b0;
        nextFlags[flagHalf]  = 1'b0;
        nextFlags[flagCarry] = 1'b0;
      end
      default:
        nextResult = alu.x;   // Plain load
    endcase
    if (alu.op != aluLoad)
      nextFlags[flagZero] = (nextResult == '0);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regA  <= '0;
      flags <= '0;
    end
    else if (alu.start)
    begin
      flags <= nextFlags;
      if (alu.writeA && (alu.op != aluCp))
        regA <= nextResult;
    end
  end

  always_ff @(posedge clk)
  begin
    if (alu.start)
      result <= nextResult;
  end

  assign alu.result = result;
  assign alu.regA   = regA;
  assign alu.flags  = flags;

  assert property (@(posedge clk) disable iff (reset)
    alu.start |-> alu.op inside {[aluAdd:aluLoad]});

endmodule

/* logic/cpuBusPkg.sv */
package cpuBusPkg;

  localparam int addrWidth = 16;
  localparam int dataWidth = 8;

  typedef logic [addrWidth-1:0] addrT;
  typedef logic [dataWidth-1:0] dataT;

  localparam addrT resetVector  = 16'h0000;
  localparam addrT highPageBase = 16'hFF00;   // LDH and LD (C) page

endpackage

/* logic/cpuIfs.sv */
`timescale 1ns/1ps

interface memPortIf import cpuBusPkg::*; ();
  logic req;
  logic we;
  addrT adr;
  dataT datW;
  logic done;     // One-cycle pulse with datR valid
  dataT datR;

  modport requester (output req, we, adr, datW, input done, datR);
  modport bus (input req, we, adr, datW, output done, datR);
endinterface

interface aluPortIf import cpuIsaPkg::*, cpuBusPkg::*; ();
  logic       start;
  aluOpT      op;
  dataT       x;
  dataT       y;
  logic       writeA;
  dataT       result;
  dataT       regA;
  logic [3:0] flags;

  modport control (
    output start, op, x, y, writeA,
    input  result, regA, flags
  );
  modport unit (
    input  start, op, x, y, writeA,
    output result, regA, flags
  );
endinterface

interface regPortIf import cpuIsaPkg::*, cpuBusPkg::*; ();
  regNumT regNum;
  dataT   dataIn;
  logic   we8;
  addrT   pairIn;
  logic   we16;
  dataT   dataOut;
  addrT   pairOut;   // Pair starting at regNum with bit 0 cleared

  modport control (
    output regNum, dataIn, we8, pairIn, we16,
    input  dataOut, pairOut
  );
  modport bank (
    input  regNum, dataIn, we8, pairIn, we16,
    output dataOut, pairOut
  );
endinterface

/* logic/cpuIsaPkg.sv */
package cpuIsaPkg;

  typedef struct packed {
    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
  } fieldsXyzT;

  typedef struct packed {
    logic [1:0] x;
    logic [1:0] p;
    logic       q;
    logic [2:0] z;
  } fieldsXpqzT;

  // Same opcode byte sliced as x/y/z or as x/p/q/z
  typedef union packed {
    fieldsXyzT  fieldsXyz;
    fieldsXpqzT fieldsXpqz;
  } opcodeT;

  typedef enum logic [3:0] {
    aluAdd  = 4'd0,   // 0 to 7 follow y of group 2
    aluAdc  = 4'd1,
    aluSub  = 4'd2,
    aluSbc  = 4'd3,
    aluAnd  = 4'd4,
    aluXor  = 4'd5,
    aluOr   = 4'd6,
    aluCp   = 4'd7,
    aluInc  = 4'd8,
    aluDec  = 4'd9,
    aluLoad = 4'd10   // X into A with flags untouched
  } aluOpT;

  localparam int flagZero  = 3;
  localparam int flagSub   = 2;
  localparam int flagHalf  = 1;
  localparam int flagCarry = 0;

  typedef logic [2:0] regNumT;

  localparam regNumT regNumB = 3'd0;
  localparam regNumT regNumC = 3'd1;
  localparam regNumT regNumD = 3'd2;
  localparam regNumT regNumE = 3'd3;
  localparam regNumT regNumH = 3'd4;
  localparam regNumT regNumL = 3'd5;
  localparam regNumT regNumA = 3'd7;   // Lives in the ALU, not the bank

  localparam logic [7:0] trapOpcode = 8'hD3;

  localparam logic [2:0] stFetch     = 3'd0;
  localparam logic [2:0] stOperand   = 3'd1;
  localparam logic [2:0] stAddress   = 3'd2;
  localparam logic [2:0] stData      = 3'd3;
  localparam logic [2:0] stWriteback = 3'd4;
  localparam logic [2:0] stTrapped   = 3'd5;

endpackage

/* logic/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import cpuBusPkg::*;
(
  input  logic clk,
  input  logic reset,
  output addrT wbAdr,
  output dataT wbDatW,
  input  dataT wbDatR,
  output logic wbWe,
  output logic wbCyc,
  output logic wbStb,
  input  logic wbAck,
  output logic trap
);

  memPortIf memPort ();
  aluPortIf aluPort ();
  regPortIf regPort ();

  instrSequencer u_instrSequencer (
    .clk   (clk),
    .reset (reset),
    .mem   (memPort.requester),
    .alu   (aluPort.control),
    .regs  (regPort.control),
    .trap  (trap)
  );

  aluUnit u_aluUnit (
    .clk   (clk),
    .reset (reset),
    .alu   (aluPort.unit)
  );

  registerBank u_registerBank (
    .clk   (clk),
    .reset (reset),
    .regs  (regPort.bank)
  );

  wishboneMaster u_wishboneMaster (
    .clk    (clk),
    .reset  (reset),
    .mem    (memPort.bus),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbWe   (wbWe),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbAck  (wbAck)
  );

endmodule

/* logic/instrSequencer.sv */
`timescale 1ns/1ps

module instrSequencer import cpuIsaPkg::*, cpuBusPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  memPortIf.requester mem,
  aluPortIf.control   alu,
  regPortIf.control   regs,
  output logic        trap
);

  logic [2:0] state;
  addrT       pc;
  opcodeT     opcode;
  opcodeT     decOp;
  dataT       operandByte;
  logic       operandHigh;
  addrT       dataAdr;
  addrT       jrTarget;
  dataT       pageOffset;
  regNumT     pairNum;
  dataT       srcVal;
  logic [1:0] opX;
  logic [2:0] opY;
  logic [2:0] opZ;
  logic [1:0] opP;
  logic       opQ;
  logic       isNop;
  logic       isLd16;
  logic       isLdInd;
  logic       isJr;
  logic       isIncDec;
  logic       isLd8;
  logic       isAluReg;
  logic       isLdhImm;
  logic       isLdhC;
  logic       isStore;
  logic       condFlag;
  logic       jrTaken;

  // Decode straight off the bus while the opcode arrives
  assign decOp = (state == stFetch) ? mem.datR : opcode;

  assign opX = decOp.fieldsXyz.x;
  assign opY = decOp.fieldsXyz.y;
  assign opZ = decOp.fieldsXyz.z;
  assign opP = decOp.fieldsXpqz.p;
  assign opQ = decOp.fieldsXpqz.q;

  assign isNop    = (decOp == 8'h00);
  assign isLd16   = (opX == 2'd0) && (opZ == 3'd1) && !opQ && (opP != 2'd3);
  assign isLdInd  = (opX == 2'd0) && (opZ == 3'd2);
  assign isJr     = (opX == 2'd0) && (opZ == 3'd0) && opY[2];
  assign isIncDec = (opX == 2'd0) && ((opZ == 3'd4) || (opZ == 3'd5)) && (opY != 3'd6);
  assign isLd8    = (opX == 2'd0) && (opZ == 3'd6) && (opY != 3'd6);
  assign isAluReg = (opX == 2'd2) && (opZ != 3'd6);
  assign isLdhImm = (opX == 2'd3) && (opZ == 3'd0) && !opQ && opP[1];
  assign isLdhC   = (opX == 2'd3) && (opZ == 3'd2) && !opQ && opP[1];

  assign isStore = (opX == 2'd0) ? !opQ : !opP[0];
  assign pairNum = opP[1] ? regNumH : (opP[0] ? regNumD : regNumB);   // HL+ and HL- share HL

  // NZ, Z, NC, C
  assign condFlag = opY[1] ? alu.flags[flagCarry] : alu.flags[flagZero];
  assign jrTaken  = (condFlag == opY[0]);
  assign jrTarget = pc + addrT'(1) + {{(addrWidth - dataWidth){mem.datR[7]}}, mem.datR};

  assign pageOffset = isLdhC ? regs.dataOut : operandByte;

  always_comb
  begin
    if (isIncDec || isLd8)
      regs.regNum = opY;
    else if (isAluReg)
      regs.regNum = opZ;
    else if (isLdhC)
      regs.regNum = regNumC;
    else
      regs.regNum = pairNum;
  end

  assign srcVal = (regs.regNum == regNumA) ? alu.regA : regs.dataOut;

  assign mem.req  = (state == stFetch) || (state == stOperand) || (state == stData);
  assign mem.adr  = (state == stData) ? dataAdr : pc;
  assign mem.we   = (state == stData) && isStore;
  assign mem.datW = alu.regA;
  assign trap     = (state == stTrapped);

  always_comb
  begin
    alu.start  = 1'b0;
    alu.op     = aluLoad;
    alu.x      = mem.datR;
    alu.y      = srcVal;
    alu.writeA = 1'b1;
    case (state)
      stFetch:
      begin
        if (isIncDec)
        begin
          alu.start  = mem.done;
          alu.op     = opZ[0] ? aluDec : aluInc;
          alu.x      = srcVal;
          alu.writeA = (opY == regNumA);
        end
        else if (isAluReg)
        begin
          alu.start = mem.done;
          alu.op    = aluOpT'({1'b0, opY});
          alu.x     = alu.regA;
        end
      end
      stOperand:
        alu.start = mem.done && isLd8 && (opY == regNumA);
      stData:
        alu.start = mem.done && !isStore;   // Loads into A
      default:
        alu.start = 1'b0;
    endcase
  end

  always_comb
  begin
    regs.we8    = 1'b0;
    regs.we16   = 1'b0;
    regs.dataIn = mem.datR;
    regs.pairIn = {mem.datR, operandByte};
    case (state)
      stOperand:
      begin
        regs.we8  = mem.done && isLd8 && (opY != regNumA);
        regs.we16 = mem.done && isLd16 && operandHigh;
      end
      stAddress:
      begin
        regs.we16   = isLdInd && opP[1];
        regs.pairIn = opP[0] ? regs.pairOut - addrT'(1) : regs.pairOut + addrT'(1);
      end
      stWriteback:
      begin
        regs.we8    = 1'b1;
        regs.dataIn = alu.result;
      end
      default:
        regs.we8 = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= stFetch;
      pc          <= resetVector;
      operandHigh <= 1'b0;
    end
    else
    begin
      case (state)
        stFetch:
        begin
          if (mem.done)
          begin
            pc <= pc + addrT'(1);
            if (isLd16 || isLd8 || isJr || isLdhImm)
              state <= stOperand;
            else if (isLdInd || isLdhC)
              state <= stAddress;
            else if (isIncDec && (opY != regNumA))
              state <= stWriteback;
            else if (isNop || isIncDec || isAluReg)
              state <= stFetch;
            else
              state <= stTrapped;
          end
        end
        stOperand:
        begin
          if (mem.done)
          begin
            pc <= (isJr && jrTaken) ? jrTarget : pc + addrT'(1);
            if (isLd16 && !operandHigh)
              operandHigh <= 1'b1;   // Low byte taken and high byte next
            else if (isLdhImm)
              state <= stAddress;
            else
            begin
              operandHigh <= 1'b0;
              state       <= stFetch;
            end
          end
        end
        stAddress:
          state <= stData;
        stData:
        begin
          if (mem.done)
            state <= stFetch;
        end
        stWriteback:
          state <= stFetch;
        default:
          state <= stTrapped;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == stFetch) && mem.done)
      opcode <= mem.datR;
    if ((state == stOperand) && mem.done)
      operandByte <= mem.datR;
    if (state == stAddress)
      dataAdr <= isLdInd ? regs.pairOut : highPageBase + addrT'(pageOffset);
  end

endmodule

/* logic/registerBank.sv */
`timescale 1ns/1ps

module registerBank import cpuIsaPkg::*, cpuBusPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  regPortIf.bank  regs
);

  dataT   regFile [regNumB:regNumL];
  regNumT hiNum;
  logic   inBank;
  logic   pairInBank;

  assign inBank     = (regs.regNum <= regNumL);
  assign hiNum      = {regs.regNum[2:1], 1'b0};
  assign pairInBank = (hiNum < regNumL);   // BC, DE, HL

  assign regs.dataOut = inBank ? regFile[regs.regNum] : '0;
  assign regs.pairOut = pairInBank ? {regFile[hiNum], regFile[{hiNum[2:1], 1'b1}]} : '0;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = regNumB; i <= regNumL; i++)
        regFile[i] <= '0;
    end
    else if (regs.we16 && pairInBank)
    begin
      regFile[hiNum]              <= regs.pairIn[15:8];
      regFile[{hiNum[2:1], 1'b1}] <= regs.pairIn[7:0];
    end
    else if (regs.we8 && inBank)
      regFile[regs.regNum] <= regs.dataIn;
  end

  assert property (@(posedge clk) disable iff (reset) !(regs.we8 && regs.we16));

endmodule

/* logic/wishboneMaster.sv */
`timescale 1ns/1ps

module wishboneMaster import cpuBusPkg::*;
(
  input  logic  clk,
  input  logic  reset,
  memPortIf.bus mem,
  output addrT  wbAdr,
  output dataT  wbDatW,
  input  dataT  wbDatR,
  output logic  wbWe,
  output logic  wbCyc,
  output logic  wbStb,
  input  logic  wbAck
);

  logic busActive;   // Idle when low

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busActive <= 1'b0;
      wbWe      <= 1'b0;
    end
    else if (!busActive)
    begin
      if (mem.req)
      begin
        busActive <= 1'b1;
        wbWe      <= mem.we;
      end
    end
    else if (wbAck)
    begin
      busActive <= 1'b0;   // Gives the idle cycle before the next request
      wbWe      <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!busActive && mem.req)
    begin
      wbAdr  <= mem.adr;
      wbDatW <= mem.datW;
    end
  end

  assign wbCyc    = busActive;
  assign wbStb    = busActive;
  assign mem.done = wbStb && wbAck;
  assign mem.datR = wbDatR;

  // Slave may stall indefinitely
  assert property (@(posedge clk) disable iff (reset)
    wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW));

endmodule

/* tb.f */
+incdir+verification
logic/cpuIsaPkg.sv
logic/cpuBusPkg.sv
logic/cpuIfs.sv
logic/instrSequencer.sv
logic/aluUnit.sv
logic/registerBank.sv
logic/wishboneMaster.sv
logic/cpuTop.sv
verification/tbCpu.sv

/* verification/isaModel.svh */
logic [7:0]  modelMem [0:65535];
logic [7:0]  mReg [0:7];      // B C D E H L then A at index 7
logic        mZ;
logic        mN;
logic        mH;
logic        mC;
logic [15:0] mPc;
logic [15:0] expAdr [$];
logic        expWe [$];
logic [7:0]  expDat [$];

function automatic logic [7:0] readExpected(logic [15:0] a);
  expAdr.push_back(a);
  expWe.push_back(1'b0);
  expDat.push_back(8'h00);
  return modelMem[a];
endfunction

task automatic writeExpected(logic [15:0] a, logic [7:0] d);
  expAdr.push_back(a);
  expWe.push_back(1'b1);
  expDat.push_back(d);
  modelMem[a] = d;
endtask

function automatic logic [15:0] getPair(logic [1:0] p);
  int hi;
  hi = (p >= 2) ? 4 : 2 * int'(p);   // HL+ and HL- both use HL
  return {mReg[hi], mReg[hi+1]};
endfunction

task automatic setPair(logic [1:0] p, logic [15:0] v);
  int hi;
  hi = (p >= 2) ? 4 : 2 * int'(p);
  mReg[hi]   = v[15:8];
  mReg[hi+1] = v[7:0];
endtask

task automatic aluExec(logic [2:0] op, logic [7:0] b);
  int         a;
  int         v;
  int         cin;
  logic [7:0] r;
  a   = int'(mReg[7]);
  v   = int'(b);
  cin = (op == 3'd1 || op == 3'd3) ? int'(mC) : 0;
  case (op)
    3'd0, 3'd1:
    begin
      r  = 8'(a + v + cin);
      mN = 1'b0;
      mH = ((a % 16) + (v % 16) + cin) > 15;
      mC = (a + v + cin) > 255;
    end
    3'd2, 3'd3, 3'd7:
    begin
      r  = 8'(a - v - cin);
      mN = 1'b1;
      mH = (a % 16) < ((v % 16) + cin);
      mC = a < (v + cin);
    end
    3'd4:
    begin
      r  = mReg[7] & b;
      mN = 1'b0;
      mH = 1'b1;
      mC = 1'b0;
    end
    default:
    begin
      r  = (op == 3'd5) ? (mReg[7] ^ b) : (mReg[7] | b);
      mN = 1'b0;
      mH = 1'b0;
      mC = 1'b0;
    end
  endcase
  mZ = (r == 8'h00);
  if (op != 3'd7)
    mReg[7] = r;   // CP only sets flags
endtask

// Runs the program to the trap opcode and fills the expected access queues
task automatic runProgram();
  logic [7:0]  op;
  logic [7:0]  lo;
  logic [7:0]  hi;
  logic [15:0] a;
  logic        done;
  int          steps;
  for (int i = 0; i < 8; i++)
    mReg[i] = 8'h00;
  {mZ, mN, mH, mC} = 4'b0000;
  mPc   = 16'h0000;
  done  = 1'b0;
  steps = 0;
  while (!done && steps < 5000)
  begin
    op  = readExpected(mPc);
    mPc = mPc + 16'd1;
    steps++;
    if (op == 8'h00)
      done = 1'b0;
    else if (op[7:6] == 2'd0 && op[2:0] == 3'd1 && !op[3] && op[5:4] != 2'd3)
    begin
      lo  = readExpected(mPc);
      hi  = readExpected(mPc + 16'd1);
      mPc = mPc + 16'd2;
      setPair(op[5:4], {hi, lo});
    end
    else if (op[7:6] == 2'd0 && op[2:0] == 3'd2)
    begin
      a = getPair(op[5:4]);
      if (op[5])
        setPair(2'd2, op[4] ? a - 16'd1 : a + 16'd1);
      if (op[3])
        mReg[7] = readExpected(a);
      else
        writeExpected(a, mReg[7]);
    end
    else if (op[7:6] == 2'd0 && (op[2:0] == 3'd4 || op[2:0] == 3'd5) && op[5:3] != 3'd6)
    begin
      lo = mReg[op[5:3]];
      hi = op[0] ? lo - 8'd1 : lo + 8'd1;
      mH = op[0] ? (lo[3:0] == 4'h0) : (lo[3:0] == 4'hF);
      mN = op[0];
      mZ = (hi == 8'h00);    // Carry untouched
      mReg[op[5:3]] = hi;
    end
    else if (op[7:6] == 2'd0 && op[2:0] == 3'd6 && op[5:3] != 3'd6)
    begin
      mReg[op[5:3]] = readExpected(mPc);
      mPc = mPc + 16'd1;
    end
    else if (op[7:6] == 2'd0 && op[2:0] == 3'd0 && op[5])
    begin
      lo  = readExpected(mPc);
      mPc = mPc + 16'd1;
      if ((op[4] ? mC : mZ) == op[3])
        mPc = mPc + {{8{lo[7]}}, lo};
    end
    else if (op[7:6] == 2'd2 && op[2:0] != 3'd6)
      aluExec(op[5:3], mReg[op[2:0]]);
    else if (op == 8'hE0 || op == 8'hF0 || op == 8'hE2 || op == 8'hF2)
    begin
      if (op[1])
        lo = mReg[1];
      else
      begin
        lo  = readExpected(mPc);
        mPc = mPc + 16'd1;
      end
      a = 16'hFF00 + {8'h00, lo};
      if (op[4])
        mReg[7] = readExpected(a);
      else
        writeExpected(a, mReg[7]);
    end
    else
      done = 1'b1;   // Trap
  end
endtask

/* verification/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu import cpuIsaPkg::*, cpuBusPkg::*;
();

  localparam int maxCycles = 20000;   // 200 instr x 4 accesses x 7 cycles plus margin

  logic clk;
  logic reset;
  addrT wbAdr;
  dataT wbDatW;
  dataT wbDatR;
  logic wbWe;
  logic wbCyc;
  logic wbStb;
  logic wbAck;
  logic trap;

  logic [7:0]  busMem [0:65535];
  logic [15:0] genPc;
  logic        inCycle;
  logic        lastStb;
  logic        firstCycle;
  int          ackWait;
  int          cycles;
  addrT        cycAdr;
  logic        cycWe;
  dataT        cycDat;

  `include "isaModel.svh"

  cpuTop u_cpuTop (
    .clk    (clk),
    .reset  (reset),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbWe   (wbWe),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbAck  (wbAck),
    .trap   (trap)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkEq(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic emit(logic [7:0] b);
    busMem[genPc]   = b;
    modelMem[genPc] = b;
    genPc = genPc + 16'd1;
  endtask

  function automatic logic [2:0] pickReg();
    logic [2:0] r;
    r = 3'($urandom % 7);
    return (r == 3'd6) ? 3'd7 : r;
  endfunction

  task automatic buildProgram();
    logic [2:0] y;
    logic [1:0] p;
    logic [1:0] k;
    int         kind;
    emit(8'h01);
    emit(8'($urandom));
    emit(8'hC0);
    emit(8'h11);
    emit(8'($urandom));
    emit(8'hC0);
    emit(8'h21);
    emit(8'($urandom));
    emit(8'hC0);
    for (int n = 0; n < 200; n++)
    begin
      kind = int'($urandom % 9);
      y    = pickReg();
      p    = 2'($urandom);
      case (kind)
        0: emit(8'h00);
        1:
        begin
          p = 2'($urandom % 3);
          emit({2'b00, p, 4'b0001});
          emit(8'($urandom));
          emit(8'hC0);
        end
        2:
        begin
          emit({2'b00, p, 1'($urandom), 3'b010});
          if (p[1])
          begin
            emit(8'h21);   // Fresh HL after the pointer moved
            emit(8'($urandom));
            emit(8'hC0);
          end
        end
        3: emit({2'b00, y, 2'b10, 1'($urandom)});
        4:
        begin
          emit({2'b00, y, 3'b110});
          // High bytes stay near C0 so pointers never reach the program
          if (y == 3'd0 || y == 3'd2 || y == 3'd4)
            emit({4'hC, 4'($urandom)});
          else
            emit(8'($urandom));
        end
        5:
        begin
          k = 2'($urandom);
          emit({3'b001, p, 3'b000});
          emit({6'd0, k});
          for (int j = 0; j < int'(k); j++)
            emit(8'h00);
        end
        6: emit({2'b10, 3'($urandom), y});
        7:
        begin
          emit(($urandom % 2) ? 8'hF0 : 8'hE0);
          emit(8'($urandom));
        end
        default: emit(($urandom % 2) ? 8'hF2 : 8'hE2);
      endcase
    end
    emit(trapOpcode);
  endtask

  task automatic respond();
    if (cycWe)
      busMem[cycAdr] = cycDat;
    else
      wbDatR = busMem[cycAdr];
    wbAck = 1'b1;
  endtask

  task automatic holdCycle();
    checkEq("wbStb", 1, 32'(wbStb));
    checkEq("wbAdr stable", 32'(cycAdr), 32'(wbAdr));
    checkEq("wbWe stable", 32'(cycWe), 32'(wbWe));
    checkEq("wbDatW stable", 32'(cycDat), 32'(wbDatW));
    if (ackWait == 0)
      respond();
    else
      ackWait--;
  endtask

  task automatic startCycle();
    if (expAdr.size() == 0)
    begin
      $display("A bus cycle started after the last expected access");
      $display(">>> FAIL");
      $fatal(1, "unexpected bus cycle");
    end
    else
    begin
      if (firstCycle)
        checkEq("first wbAdr", 32'(resetVector), 32'(wbAdr));
      firstCycle = 1'b0;
      checkEq("idle before wbStb", 0, 32'(lastStb));
      checkEq("wbCyc", 1, 32'(wbCyc));
      checkEq("wbAdr", 32'(expAdr[0]), 32'(wbAdr));
      checkEq("wbWe", 32'(expWe[0]), 32'(wbWe));
      if (wbWe)
        checkEq("wbDatW", 32'(expDat[0]), 32'(wbDatW));
      void'(expAdr.pop_front());
      void'(expWe.pop_front());
      void'(expDat.pop_front());
      cycAdr  = wbAdr;
      cycWe   = wbWe;
      cycDat  = wbDatW;
      inCycle = 1'b1;
      ackWait = int'($urandom % 4);
      holdCycle();
    end
  endtask

  // Wishbone slave driven on the falling edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (wbAck)
      begin
        wbAck   = 1'b0;
        inCycle = 1'b0;
      end
      else if (wbStb && !inCycle)
        startCycle();
      else if (inCycle)
        holdCycle();
      lastStb = wbStb;
    end
  end

  always @(posedge clk)
  begin
    if (cycles >= maxCycles)
    begin
      $display("Timeout: the core did not reach the trap within %0d cycles", maxCycles);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
    else
      cycles++;
  end

  initial
  begin
    void'($urandom(32'hf1bc));
    reset      = 1'b1;
    wbAck      = 1'b0;
    wbDatR     = 8'h00;
    inCycle    = 1'b0;
    lastStb    = 1'b0;
    firstCycle = 1'b1;
    ackWait    = 0;
    cycles     = 0;
    genPc      = 16'h0000;
    for (int i = 0; i < 65536; i++)
    begin
      busMem[i]   = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;   // Whole address in the fill
      modelMem[i] = busMem[i];
    end
    buildProgram();
    runProgram();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    checkEq("wbCyc after reset", 0, 32'(wbCyc));
    checkEq("wbStb after reset", 0, 32'(wbStb));
    checkEq("wbWe after reset", 0, 32'(wbWe));
    checkEq("trap after reset", 0, 32'(trap));
    while (!trap)
      @(negedge clk);
    repeat (8)
    begin
      @(negedge clk);
      checkEq("wbCyc after trap", 0, 32'(wbCyc));
      checkEq("trap held", 1, 32'(trap));
    end
    checkEq("accesses left", 0, 32'(expAdr.size()));
    $display(">>> PASS");
    $finish;
  end

endmodule
